/* rtl/dma_ctrl_pkg.sv */
// DMA control block shared definitions
// register map, bus widths, TLB command and statistics layouts, FSM states

package dma_ctrl_pkg;

  // widths that carry a meaning
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [6:0]  reg_idx_t;   // addr[11:5], 32-byte register stride
  typedef logic [47:0] len_cnt_t;
  typedef logic [3:0]  stat_idx_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // register map
  localparam reg_idx_t REG_TLB        = 7'h02;
  localparam reg_idx_t REG_BOARDNUM   = 7'h07;
  localparam reg_idx_t REG_DMA_READS  = 7'h0A;
  localparam reg_idx_t REG_DMA_WRITES = 7'h0B;
  localparam reg_idx_t REG_STATS      = 7'h0D;

  localparam int TLB_WORDS = 5;   // four address/data words plus the flag word
  localparam int NUM_STATS = 10;

  localparam axil_data_t BAD_READ_DATA = 32'hDEADBEEF;

  localparam int AXIL_TIMEOUT_CYCLES = 200;  // per-channel wait limit in the testbench

  typedef struct packed {
    logic [6:0]   pad;        // always zero
    logic         cmd_flag;   // bit 0 of the fifth word
    logic [127:0] addr_data;  // word 0 at the bottom
  } tlb_cmd_t;

  typedef struct packed {
    axil_data_t write_cmd;
    axil_data_t write_word;
    axil_data_t write_pkg;
    axil_data_t read_cmd;
    axil_data_t read_word;
    axil_data_t read_pkg;
    axil_data_t tlb_miss;
    axil_data_t tlb_page_cross;
    len_cnt_t   write_len;
    len_cnt_t   read_len;
    logic       reads_flushed;
  } dma_stats_t;

  typedef struct packed {
    logic       board_num_valid;  // one-cycle strobe
    logic [3:0] board_num;
    logic       reset_write_len;  // one-cycle strobe
    logic       reset_read_len;   // one-cycle strobe
  } cfg_cmd_t;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_WAIT_TLB, WR_RESP} wr_state_e;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

endpackage

/* rtl/axil_write_ctrl.sv */
`timescale 1ns/1ps

// AXI-Lite write path
// one address, one data beat, one response; decodes the register index,
// fires the config strobes and forwards TLB words to the command builder

module axil_write_ctrl
  import dma_ctrl_pkg::*;
(
  input  logic       user_clk,
  input  logic       user_aresetn,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic       wvalid,
  output logic       wready,
  output axil_resp_t bresp,
  output logic       bvalid,
  input  logic       bready,
  output cfg_cmd_t   cfg,
  output logic       word_valid,
  output axil_data_t word_data,
  input  logic       word_ack
);

  wr_state_e state;
  reg_idx_t  wr_idx;   // register index of the write in flight

  assign bresp = RESP_OKAY;  // unmapped writes are silently accepted

  // address and data capture
  always_ff @(posedge user_clk) begin
    if (awvalid && awready) begin
      wr_idx <= awaddr[11:5];
    end
    if (wvalid && wready) begin
      word_data <= wdata;  // only consumed for REG_TLB
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state      <= WR_IDLE;
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      word_valid <= 1'b0;
      cfg        <= '0;
    end else begin
      // strobes default low
      word_valid          <= 1'b0;
      cfg.board_num_valid <= 1'b0;
      cfg.reset_write_len <= 1'b0;
      cfg.reset_read_len  <= 1'b0;

      case (state)
        WR_IDLE: begin
          awready <= 1'b1;
          if (awvalid && awready) begin
            awready <= 1'b0;
            wready  <= 1'b1;   // data beat next
            state   <= WR_DATA;
          end
        end

        WR_DATA: begin
          if (wvalid && wready) begin
            wready <= 1'b0;
            if (wr_idx == REG_TLB) begin
              word_valid <= 1'b1;  // builder acks when absorbed
              state      <= WR_WAIT_TLB;
            end else begin
              bvalid <= 1'b1;
              state  <= WR_RESP;
              case (wr_idx)
                REG_BOARDNUM: begin
                  cfg.board_num_valid <= 1'b1;
                  cfg.board_num       <= wdata[3:0];
                end
                REG_DMA_READS:  cfg.reset_read_len  <= 1'b1;
                REG_DMA_WRITES: cfg.reset_write_len <= 1'b1;
                default: ;  // no side effect
              endcase
            end
          end
        end

        WR_WAIT_TLB: begin
          // ack is late on word 4 while the TLB stream is stalled
          if (word_ack) begin
            bvalid <= 1'b1;
            state  <= WR_RESP;
          end
        end

        WR_RESP: begin
          if (bvalid && bready) begin
            bvalid  <= 1'b0;
            awready <= 1'b1;  // ready for the next address
            state   <= WR_IDLE;
          end
        end

        default: state <= WR_IDLE;
      endcase
    end
  end

  // a new address is never taken while a response is still owed
  a_no_aw_during_b: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    !(bvalid && awready));

  a_b_held: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    bvalid && !bready |=> bvalid);

endmodule

/* rtl/tlb_cmd_builder.sv */
`timescale 1ns/1ps

// TLB command builder
// packs five register writes into one command and sends it on a valid/ready stream

module tlb_cmd_builder
  import dma_ctrl_pkg::*;
(
  input  logic       user_clk,
  input  logic       user_aresetn,
  input  logic       word_valid,
  input  axil_data_t word_data,
  output logic       word_ack,
  output tlb_cmd_t   tlb_cmd,
  output logic       tlb_valid,
  input  logic       tlb_ready
);

  logic [$clog2(TLB_WORDS)-1:0] word_cnt;  // kept across other register writes
  logic [127:0]                 addr_data_q;
  logic                         cmd_flag_q;

  assign tlb_cmd = '{pad: '0, cmd_flag: cmd_flag_q, addr_data: addr_data_q};

  // payload
  always_ff @(posedge user_clk) begin
    if (word_valid) begin
      if (word_cnt == ($clog2(TLB_WORDS))'(TLB_WORDS - 1)) begin
        cmd_flag_q <= word_data[0];
      end else begin
        addr_data_q[word_cnt*32 +: 32] <= word_data;
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      word_cnt  <= '0;
      word_ack  <= 1'b0;
      tlb_valid <= 1'b0;
    end else begin
      word_ack <= 1'b0;
      if (word_valid) begin
        if (word_cnt == ($clog2(TLB_WORDS))'(TLB_WORDS - 1)) begin
          tlb_valid <= 1'b1;  // last word, ack waits for the stream
        end else begin
          word_cnt <= word_cnt + 1'b1;
          word_ack <= 1'b1;
        end
      end
      if (tlb_valid && tlb_ready) begin
        tlb_valid <= 1'b0;
        word_cnt  <= '0;    // only a sent command clears the count
        word_ack  <= 1'b1;
      end
    end
  end

  a_cmd_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    tlb_valid && !tlb_ready |=> $stable(tlb_cmd));

endmodule

/* rtl/axil_read_ctrl.sv */
`timescale 1ns/1ps

// AXI-Lite read path
// takes one address, latches the selected register value and holds it until rready

module axil_read_ctrl
  import dma_ctrl_pkg::*;
(
  input  logic       user_clk,
  input  logic       user_aresetn,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  output logic       rvalid,
  input  logic       rready,
  output reg_idx_t   rd_idx,
  input  axil_data_t rd_data,
  input  axil_resp_t rd_resp,
  output logic       rd_advance
);

  rd_state_e state;
  reg_idx_t  idx_q;   // index of the read in flight

  // mux sees the incoming address while idle so data is ready on the AR edge
  assign rd_idx     = (state == RD_IDLE) ? araddr[11:5] : idx_q;
  assign rd_advance = rvalid && rready;

  always_ff @(posedge user_clk) begin
    if (arvalid && arready) begin
      idx_q <= araddr[11:5];
      rdata <= rd_data;   // latched once, held for the response
      rresp <= rd_resp;
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state   <= RD_IDLE;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          arready <= 1'b1;
          if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            state   <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (rvalid && rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
            state   <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  a_rdata_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    rvalid && !rready |=> $stable(rdata));

endmodule

/* rtl/stats_read_mux.sv */
`timescale 1ns/1ps

// read data select for the DMA counters
// length registers alternate low/high words, the stats register rotates
// through ten counters, anything else answers SLVERR

module stats_read_mux
  import dma_ctrl_pkg::*;
(
  input  logic       user_clk,
  input  logic       user_aresetn,
  input  dma_stats_t stats,
  input  reg_idx_t   rd_idx,
  output axil_data_t rd_data,
  output axil_resp_t rd_resp,
  input  logic       rd_advance
);

  logic       read_hi;    // next read of REG_DMA_READS returns upper half
  logic       write_hi;   // same for REG_DMA_WRITES
  stat_idx_t  stat_idx;
  axil_data_t stat_word;

  // low 32 bits, or upper 16 zero-extended
  function automatic axil_data_t len_half(input len_cnt_t len, input logic hi);
    return hi ? {16'h0000, len[47:32]} : len[31:0];
  endfunction

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      read_hi  <= 1'b0;
      write_hi <= 1'b0;
      stat_idx <= '0;
    end else if (rd_advance) begin
      case (rd_idx)
        REG_DMA_READS:  read_hi  <= ~read_hi;  // flips even before flush
        REG_DMA_WRITES: write_hi <= ~write_hi;
        REG_STATS: begin
          if (stat_idx == stat_idx_t'(NUM_STATS - 1)) begin
            stat_idx <= '0;
          end else begin
            stat_idx <= stat_idx + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // statistics rotation order
  always_comb begin
    case (stat_idx)
      4'd0:    stat_word = stats.write_cmd;
      4'd1:    stat_word = stats.write_word;
      4'd2:    stat_word = stats.write_pkg;
      4'd3:    stat_word = stats.write_len[31:0];
      4'd4:    stat_word = stats.read_cmd;
      4'd5:    stat_word = stats.read_word;
      4'd6:    stat_word = stats.read_pkg;
      4'd7:    stat_word = stats.read_len[31:0];
      4'd8:    stat_word = stats.tlb_miss;
      4'd9:    stat_word = stats.tlb_page_cross;
      default: stat_word = '0;   // index wraps at 9
    endcase
  end

  always_comb begin
    rd_resp = RESP_OKAY;
    case (rd_idx)
      REG_DMA_READS: begin
        // read length not meaningful until in-flight reads drain
        rd_data = stats.reads_flushed ? len_half(stats.read_len, read_hi) : '0;
      end
      REG_DMA_WRITES: rd_data = len_half(stats.write_len, write_hi);
      REG_STATS:      rd_data = stat_word;
      default: begin
        rd_data = BAD_READ_DATA;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

endmodule

/* rtl/dma_ctrl_top.sv */
`timescale 1ns/1ps

// DMA register-access control block
// AXI-Lite slave split into write path, TLB command builder, read path and read mux

module dma_ctrl_top
  import dma_ctrl_pkg::*;
(
  input  logic       user_clk,
  input  logic       user_aresetn,
  // AXI-Lite slave
  input  axil_addr_t s_axil_awaddr,
  input  logic       s_axil_awvalid,
  output logic       s_axil_awready,
  input  axil_data_t s_axil_wdata,
  input  logic [3:0] s_axil_wstrb,    // full-word writes only, strobes unused
  input  logic       s_axil_wvalid,
  output logic       s_axil_wready,
  output axil_resp_t s_axil_bresp,
  output logic       s_axil_bvalid,
  input  logic       s_axil_bready,
  input  axil_addr_t s_axil_araddr,
  input  logic       s_axil_arvalid,
  output logic       s_axil_arready,
  output axil_data_t s_axil_rdata,
  output axil_resp_t s_axil_rresp,
  output logic       s_axil_rvalid,
  input  logic       s_axil_rready,
  // DMA engine side
  input  dma_stats_t stats,
  output cfg_cmd_t   cfg,
  output tlb_cmd_t   tlb_cmd,
  output logic       tlb_valid,
  input  logic       tlb_ready
);

  logic       word_valid;   // write ctrl -> builder
  axil_data_t word_data;
  logic       word_ack;     // builder -> write ctrl
  reg_idx_t   rd_idx;
  axil_data_t rd_data;
  axil_resp_t rd_resp;
  logic       rd_advance;

  axil_write_ctrl u_write_ctrl (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .awaddr       (s_axil_awaddr),
    .awvalid      (s_axil_awvalid),
    .awready      (s_axil_awready),
    .wdata        (s_axil_wdata),
    .wvalid       (s_axil_wvalid),
    .wready       (s_axil_wready),
    .bresp        (s_axil_bresp),
    .bvalid       (s_axil_bvalid),
    .bready       (s_axil_bready),
    .cfg          (cfg),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .word_ack     (word_ack)
  );

  tlb_cmd_builder u_tlb_builder (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .word_ack     (word_ack),
    .tlb_cmd      (tlb_cmd),
    .tlb_valid    (tlb_valid),
    .tlb_ready    (tlb_ready)
  );

  axil_read_ctrl u_read_ctrl (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .araddr       (s_axil_araddr),
    .arvalid      (s_axil_arvalid),
    .arready      (s_axil_arready),
    .rdata        (s_axil_rdata),
    .rresp        (s_axil_rresp),
    .rvalid       (s_axil_rvalid),
    .rready       (s_axil_rready),
    .rd_idx       (rd_idx),
    .rd_data      (rd_data),
    .rd_resp      (rd_resp),
    .rd_advance   (rd_advance)
  );

  stats_read_mux u_stats_mux (
    .user_clk     (user_clk),
    .user_aresetn (user_aresetn),
    .stats        (stats),
    .rd_idx       (rd_idx),
    .rd_data      (rd_data),
    .rd_resp      (rd_resp),
    .rd_advance   (rd_advance)
  );

endmodule

/* include/tb_axil_tasks.svh */
// AXI-Lite master tasks for the DMA control testbench
// drive on the falling edge, every wait loop bounded by its own timeout

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

function automatic axil_addr_t reg_addr(input reg_idx_t idx);
  return axil_addr_t'(idx) << 5;  // 32-byte register stride
endfunction

task automatic axil_timeout(input string chan);
  $display("Fail: AXI-Lite %s channel timed out", chan);
  $display("Test failed");
  $fatal(1);
endtask

// address and data beats, response left pending
task automatic axil_send_aw_w(input axil_addr_t addr, input axil_data_t data);
  int unsigned n;
  @(negedge user_clk);
  s_axil_awaddr  = addr;
  s_axil_awvalid = 1'b1;
  n = 0;
  while (!s_axil_awready) begin
    @(negedge user_clk);
    n++;
    if (n > AXIL_TIMEOUT_CYCLES) axil_timeout("AW");
  end
  @(negedge user_clk);  // AW taken on the edge just passed
  s_axil_awvalid = 1'b0;
  s_axil_wdata   = data;
  s_axil_wstrb   = 4'hF;
  s_axil_wvalid  = 1'b1;
  n = 0;
  while (!s_axil_wready) begin
    @(negedge user_clk);
    n++;
    if (n > AXIL_TIMEOUT_CYCLES) axil_timeout("W");
  end
  @(negedge user_clk);
  s_axil_wvalid = 1'b0;
endtask

task automatic axil_wait_b(output axil_resp_t resp);
  int unsigned n;
  s_axil_bready = 1'b1;
  n = 0;
  while (!s_axil_bvalid) begin
    @(negedge user_clk);
    n++;
    if (n > AXIL_TIMEOUT_CYCLES) axil_timeout("B");
  end
  resp = s_axil_bresp;
  @(negedge user_clk);
  s_axil_bready = 1'b0;
endtask

task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          output axil_resp_t resp);
  axil_send_aw_w(addr, data);
  axil_wait_b(resp);
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                         output axil_resp_t resp);
  int unsigned n;
  @(negedge user_clk);
  s_axil_araddr  = addr;
  s_axil_arvalid = 1'b1;
  n = 0;
  while (!s_axil_arready) begin
    @(negedge user_clk);
    n++;
    if (n > AXIL_TIMEOUT_CYCLES) axil_timeout("AR");
  end
  @(negedge user_clk);
  s_axil_arvalid = 1'b0;
  s_axil_rready  = 1'b1;
  n = 0;
  while (!s_axil_rvalid) begin
    @(negedge user_clk);
    n++;
    if (n > AXIL_TIMEOUT_CYCLES) axil_timeout("R");
  end
  data = s_axil_rdata;
  resp = s_axil_rresp;
  @(negedge user_clk);
  s_axil_rready = 1'b0;
endtask

`endif

/* testbench/tb_dma_ctrl.sv */
`timescale 1ns/1ps

// testbench for the DMA register-access control block
// directed AXI-Lite tests of reset state, TLB command, config strobes,
// length counter halves, stats rotation and the unmapped read

module tb_dma_ctrl
  import dma_ctrl_pkg::*;
();

  logic        user_clk;
  logic        user_aresetn;
  axil_addr_t  s_axil_awaddr;
  logic        s_axil_awvalid;
  logic        s_axil_awready;
  axil_data_t  s_axil_wdata;
  logic [3:0]  s_axil_wstrb;
  logic        s_axil_wvalid;
  logic        s_axil_wready;
  axil_resp_t  s_axil_bresp;
  logic        s_axil_bvalid;
  logic        s_axil_bready;
  axil_addr_t  s_axil_araddr;
  logic        s_axil_arvalid;
  logic        s_axil_arready;
  axil_data_t  s_axil_rdata;
  axil_resp_t  s_axil_rresp;
  logic        s_axil_rvalid;
  logic        s_axil_rready;
  dma_stats_t  stats;          // counter values seen by the DUT
  cfg_cmd_t    cfg;
  tlb_cmd_t    tlb_cmd;
  logic        tlb_valid;
  logic        tlb_ready;
  logic [31:0] lcg_state;      // random source seeded at start

  dma_ctrl_top UUT (.*);

  `include "tb_axil_tasks.svh"

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;  // 8 ns period
  end

  function automatic axil_data_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_word(input string what, input axil_data_t got, input axil_data_t exp);
    assert (got === exp) else begin
      $display("Fail: time %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Fail: time %0t: %s got %b expected %b", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_wait(input string what);
    $display("Timed out waiting for %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic fill_stats();
    axil_data_t lo_w;
    axil_data_t hi_w;
    axil_data_t lo_r;
    axil_data_t hi_r;
    stats.write_cmd      = lcg_next();
    stats.write_word     = lcg_next();
    stats.write_pkg      = lcg_next();
    stats.read_cmd       = lcg_next();
    stats.read_word      = lcg_next();
    stats.read_pkg       = lcg_next();
    stats.tlb_miss       = lcg_next();
    stats.tlb_page_cross = lcg_next();
    lo_w = lcg_next();
    hi_w = lcg_next();
    lo_r = lcg_next();
    hi_r = lcg_next();
    stats.write_len     = {hi_w[15:0], lo_w};  // 48-bit counters
    stats.read_len      = {hi_r[15:0], lo_r};
    stats.reads_flushed = 1'b0;                // reads still in flight
  endtask

  task automatic test_reset();
    @(negedge user_clk);  // first cycle out of reset
    check_bit("awready after reset", s_axil_awready, 1'b1);
    check_bit("arready after reset", s_axil_arready, 1'b1);
    check_bit("bvalid after reset", s_axil_bvalid, 1'b0);
    check_bit("rvalid after reset", s_axil_rvalid, 1'b0);
    check_bit("tlb_valid after reset", tlb_valid, 1'b0);
    check_word("cfg after reset", axil_data_t'(cfg), '0);
  endtask

  task automatic test_tlb_command();
    axil_data_t  w [TLB_WORDS];
    tlb_cmd_t    exp;
    axil_resp_t  resp;
    int unsigned n;
    for (int i = 0; i < TLB_WORDS; i++) begin
      w[i] = lcg_next();
    end
    exp.pad       = '0;
    exp.cmd_flag  = w[TLB_WORDS-1][0];         // only bit 0 of the fifth word
    exp.addr_data = {w[3], w[2], w[1], w[0]};  // word 0 lowest
    tlb_ready = 1'b0;
    for (int i = 0; i < TLB_WORDS - 1; i++) begin
      axil_write(reg_addr(REG_TLB), w[i], resp);
      check_word("tlb word bresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
      check_bit("tlb_valid before last word", tlb_valid, 1'b0);
    end
    axil_send_aw_w(reg_addr(REG_TLB), w[TLB_WORDS-1]);
    n = 0;
    while (!tlb_valid) begin
      @(negedge user_clk);
      n++;
      if (n > AXIL_TIMEOUT_CYCLES) abort_wait("tlb_valid");
    end
    repeat (4) begin  // no B while the stream is stalled
      check_bit("bvalid under back-pressure", s_axil_bvalid, 1'b0);
      check_bit("tlb_valid held", tlb_valid, 1'b1);
      @(negedge user_clk);
    end
    assert (tlb_cmd === exp) else begin
      $display("Fail: time %0t: tlb_cmd got %h expected %h", $time, tlb_cmd, exp);
      $display("Test failed");
      $fatal(1);
    end
    tlb_ready = 1'b1;
    @(negedge user_clk);  // stream handshake on the edge between
    tlb_ready = 1'b0;
    check_bit("tlb_valid after handshake", tlb_valid, 1'b0);
    axil_wait_b(resp);
    check_word("tlb last bresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
  endtask

  // length register write pulses its reset with bvalid for one cycle
  task automatic check_len_reset(input reg_idx_t idx, input logic is_read);
    axil_resp_t resp;
    axil_send_aw_w(reg_addr(idx), lcg_next());
    check_bit("bvalid with reset strobe", s_axil_bvalid, 1'b1);
    check_bit("reset_read_len", cfg.reset_read_len, is_read);
    check_bit("reset_write_len", cfg.reset_write_len, !is_read);
    @(negedge user_clk);
    check_bit("reset_read_len width", cfg.reset_read_len, 1'b0);
    check_bit("reset_write_len width", cfg.reset_write_len, 1'b0);
    axil_wait_b(resp);
    check_word("reset write bresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
  endtask

  task automatic test_cfg_pulses();
    axil_data_t v;
    axil_resp_t resp;
    v = lcg_next();
    axil_send_aw_w(reg_addr(REG_BOARDNUM), v);
    check_bit("bvalid with board strobe", s_axil_bvalid, 1'b1);
    check_bit("board_num_valid", cfg.board_num_valid, 1'b1);
    check_word("board_num", axil_data_t'(cfg.board_num), axil_data_t'(v[3:0]));
    check_bit("no read reset on board write", cfg.reset_read_len, 1'b0);
    check_bit("no write reset on board write", cfg.reset_write_len, 1'b0);
    @(negedge user_clk);
    check_bit("board_num_valid width", cfg.board_num_valid, 1'b0);
    axil_wait_b(resp);
    check_word("board write bresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
    check_len_reset(REG_DMA_READS, 1'b1);
    check_len_reset(REG_DMA_WRITES, 1'b0);
  endtask

  task automatic test_length_reads();
    axil_data_t d;
    axil_resp_t resp;
    for (int i = 0; i < 4; i++) begin  // low, high, low, high
      axil_read(reg_addr(REG_DMA_WRITES), d, resp);
      check_word("write_len word", d,
                 (i % 2) ? {16'h0000, stats.write_len[47:32]} : stats.write_len[31:0]);
      check_word("write_len rresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
    end
    for (int i = 0; i < 3; i++) begin  // toggle flips while the data reads zero
      axil_read(reg_addr(REG_DMA_READS), d, resp);
      check_word("read_len before flush", d, '0);
    end
    @(negedge user_clk);
    stats.reads_flushed = 1'b1;
    for (int i = 0; i < 2; i++) begin  // odd count so far so high half first
      axil_read(reg_addr(REG_DMA_READS), d, resp);
      check_word("read_len after flush", d,
                 (i % 2) ? stats.read_len[31:0] : {16'h0000, stats.read_len[47:32]});
    end
  endtask

  task automatic test_stats_rotation();
    axil_data_t exp_q[$];
    axil_data_t e;
    axil_data_t d;
    axil_resp_t resp;
    exp_q.push_back(stats.write_cmd);
    exp_q.push_back(stats.write_word);
    exp_q.push_back(stats.write_pkg);
    exp_q.push_back(stats.write_len[31:0]);
    exp_q.push_back(stats.read_cmd);
    exp_q.push_back(stats.read_word);
    exp_q.push_back(stats.read_pkg);
    exp_q.push_back(stats.read_len[31:0]);
    exp_q.push_back(stats.tlb_miss);
    exp_q.push_back(stats.tlb_page_cross);
    for (int i = 0; i < 12; i++) begin  // wraps after ten
      e = exp_q.pop_front();
      exp_q.push_back(e);
      axil_read(reg_addr(REG_STATS), d, resp);
      check_word("stats word", d, e);
      check_word("stats rresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
    end
  endtask

  task automatic test_unmapped_read();
    axil_data_t d;
    axil_resp_t resp;
    axil_read(reg_addr(7'h05), d, resp);
    check_word("unmapped rdata", d, BAD_READ_DATA);
    check_word("unmapped rresp", axil_data_t'(resp), axil_data_t'(RESP_SLVERR));
  endtask

  initial begin
    lcg_state      = 32'd12;
    user_aresetn   = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    tlb_ready      = 1'b0;
    fill_stats();
    repeat (5) @(posedge user_clk);  // reset held 5 cycles
    @(negedge user_clk);
    user_aresetn = 1'b1;
    test_reset();
    test_tlb_command();
    test_cfg_pulses();
    test_length_reads();
    test_stats_rotation();
    test_unmapped_read();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* dma_ctrl.f */
+incdir+include
rtl/dma_ctrl_pkg.sv
rtl/axil_write_ctrl.sv
rtl/tlb_cmd_builder.sv
rtl/axil_read_ctrl.sv
rtl/stats_read_mux.sv
rtl/dma_ctrl_top.sv
testbench/tb_dma_ctrl.sv

/* Makefile */
# Verilator simulation of the DMA register-access control block

VERILATOR ?= verilator
TOP       ?= tb_dma_ctrl
FILELIST  ?= dma_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

# build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
